//--- src/ahb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB3-Lite protocol encodings.
// Transfer type and transfer size as seen on the bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ahb_pkg;

   // htrans field.
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_e;

   // hsize field, only up to a 32-bit bus.
   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'b000,
      HSIZE_HALF = 3'b001,
      HSIZE_WORD = 3'b010
   } hsize_e;

endpackage : ahb_pkg

`default_nettype wire

//--- src/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory data word view.
// One 32-bit word seen as byte lanes or as halfwords.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_pkg;

   // lanes per data word.
   localparam int BYTE_LANES = 4;

   // width of one lane.
   localparam int LANE_W = 8;

   // lane 0 sits in the low bits, as on the AHB data bus.
   typedef union packed {
      logic [BYTE_LANES-1:0][LANE_W-1:0]   bytes;
      logic [1:0][2*LANE_W-1:0]            halves;
   } data_word_u;

endpackage : mem_pkg

`default_nettype wire

//--- src/ahb_cmd_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB3-Lite command master.
// Turns client command strobes into pipelined address
// and data phases, and tags the data phase of reads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ahb_cmd_master
   import ahb_pkg::*;
#(
   parameter int MEM_SIZE = 4096,
   localparam int AW = $clog2(MEM_SIZE)
) (
   input  logic          s_clk_i,
   input  logic          s_resetn_i,

   input  logic          cmd_valid_i,
   input  logic          cmd_write_i,
   input  logic [AW-1:0] cmd_addr_i,
   input  hsize_e        cmd_size_i,
   input  logic [31:0]   cmd_wdata_i,

   output logic [AW-1:0] s_haddr_o,
   output htrans_e       s_htrans_o,
   output hsize_e        s_hsize_o,
   output logic          s_hwrite_o,
   output logic          s_hsel_o,
   output logic [31:0]   s_hwdata_o,

   output logic          rd_phase_o,
   output hsize_e        rd_size_o,
   output logic [1:0]    rd_lane_o
);

   // write data waiting for its data phase.
   logic [31:0] r_wdata;

   // address phase control and the read tag.
   always_ff @(posedge s_clk_i) begin
      if (!s_resetn_i) begin
         s_htrans_o <= HTRANS_IDLE;
         s_hsel_o   <= 1'b0;
         s_hwrite_o <= 1'b0;
         rd_phase_o <= 1'b0;
      end else begin
         s_htrans_o <= cmd_valid_i ? HTRANS_NONSEQ : HTRANS_IDLE;
         s_hsel_o   <= cmd_valid_i;
         s_hwrite_o <= cmd_valid_i & cmd_write_i;
         // a read address phase becomes a read data phase.
         rd_phase_o <= s_hsel_o & (s_htrans_o == HTRANS_NONSEQ) & ~s_hwrite_o;
      end
   end

   // address phase payload, held steady between commands.
   always_ff @(posedge s_clk_i) begin
      if (cmd_valid_i) begin
         s_haddr_o <= cmd_addr_i;
         s_hsize_o <= cmd_size_i;
         r_wdata   <= cmd_wdata_i;
      end
   end

   // data phase payload, one cycle behind.
   always_ff @(posedge s_clk_i) begin
      s_hwdata_o <= r_wdata;
      rd_size_o  <= s_hsize_o;
      rd_lane_o  <= s_haddr_o[1:0];
   end

endmodule : ahb_cmd_master

`default_nettype wire

//--- src/ahb_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB3-Lite single-port RAM slave.
// Byte-lane writes and write-to-read forwarding,
// no wait states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ahb_ram
   import ahb_pkg::*;
   import mem_pkg::*;
#(
   parameter int MEM_SIZE = 4096,
   localparam int AW = $clog2(MEM_SIZE)
) (
   input  logic          s_clk_i,
   input  logic          s_resetn_i,

   input  logic [AW-1:0] s_haddr_i,
   input  logic [31:0]   s_hwdata_i,
   input  hsize_e        s_hsize_i,
   input  htrans_e       s_htrans_i,
   input  logic          s_hwrite_i,
   input  logic          s_hsel_i,

   output logic [31:0]   s_hrdata_o
);

   localparam int WORDS = MEM_SIZE / BYTE_LANES;

   logic [31:0]           r_memory [WORDS] = '{default: '0};
   logic [AW-1:0]         r_address;
   logic [AW-1:0]         r_paddress;
   hsize_e                r_size;
   logic                  r_write;
   logic                  r_wtor;
   data_word_u            r_data;
   data_word_u            r_wtor_data;
   data_word_u            s_read_data;
   data_word_u            s_write_data;
   data_word_u            s_hwdata;
   logic [BYTE_LANES-1:0] s_wea;
   logic                  s_accept;

   assign s_accept = s_hsel_i & (s_htrans_i == HTRANS_NONSEQ);
   assign s_hwdata = s_hwdata_i;

   // lanes written by the current data phase.
   always_comb begin
      case (r_size)
         HSIZE_BYTE: s_wea = 4'b0001 << r_address[1:0];
         HSIZE_HALF: s_wea = r_address[1] ? 4'b1100 : 4'b0011;
         default:    s_wea = 4'b1111;
      endcase
      if (!r_write) begin
         s_wea = '0;
      end
   end

   // the array lags one write behind, so take the merged word
   // of the previous data phase when it hit the same word.
   assign s_read_data = (r_wtor && (r_address[AW-1:2] == r_paddress[AW-1:2])) ?
                        r_wtor_data : r_data;
   assign s_hrdata_o  = s_read_data;

   // new lanes over the current word contents.
   always_comb begin
      for (int i = 0; i < BYTE_LANES; i++) begin
         s_write_data.bytes[i] = s_wea[i] ? s_hwdata.bytes[i] : s_read_data.bytes[i];
      end
   end

   // array write per lane, read with the address phase address.
   always_ff @(posedge s_clk_i) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
         if (s_wea[i]) begin
            r_memory[r_address[AW-1:2]][i*LANE_W +: LANE_W] <= s_hwdata.bytes[i];
         end
      end
      r_data <= r_memory[s_haddr_i[AW-1:2]];
   end

   always_ff @(posedge s_clk_i) begin
      if (!s_resetn_i) begin
         r_write <= 1'b0;
         r_wtor  <= 1'b0;
      end else begin
         r_write <= s_accept & s_hwrite_i;
         // forward only into a data phase that directly follows.
         r_wtor  <= s_accept & r_write;
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (s_accept) begin
         r_address <= s_haddr_i;
         r_size    <= s_hsize_i;
      end
      r_paddress  <= r_address;
      r_wtor_data <= s_write_data;
   end

endmodule : ahb_ram

`default_nettype wire

//--- src/ahb_rsp_unpack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read response unpacker.
// Returns the addressed lanes right-aligned, zero-extended.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ahb_rsp_unpack
   import ahb_pkg::*;
   import mem_pkg::*;
(
   input  logic        s_clk_i,
   input  logic        s_resetn_i,

   input  logic [31:0] s_hrdata_i,
   input  logic        rd_phase_i,
   input  hsize_e      rd_size_i,
   input  logic [1:0]  rd_lane_i,

   output logic        rsp_valid_o,
   output logic [31:0] rsp_data_o
);

   data_word_u  s_word;
   logic [31:0] s_sel;

   assign s_word = s_hrdata_i;

   // lane select, the cast zero-extends.
   always_comb begin
      case (rd_size_i)
         HSIZE_BYTE: s_sel = 32'(s_word.bytes[rd_lane_i]);
         HSIZE_HALF: s_sel = 32'(s_word.halves[rd_lane_i[1]]);
         default:    s_sel = s_word;
      endcase
   end

   always_ff @(posedge s_clk_i) begin
      if (!s_resetn_i) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= rd_phase_i;
      end
   end

   // response data only moves on a read data phase.
   always_ff @(posedge s_clk_i) begin
      if (rd_phase_i) begin
         rsp_data_o <= s_sel;
      end
   end

endmodule : ahb_rsp_unpack

`default_nettype wire

//--- src/ahb_ram_sys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB3-Lite RAM subsystem.
// Command master, RAM slave and response unpacker
// in a fixed three-cycle pipeline.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ahb_ram_sys
   import ahb_pkg::*;
#(
   parameter int MEM_SIZE = 4096,
   localparam int AW = $clog2(MEM_SIZE)
) (
   input  logic          s_clk_i,
   input  logic          s_resetn_i,

   input  logic          cmd_valid_i,
   input  logic          cmd_write_i,
   input  logic [AW-1:0] cmd_addr_i,
   input  hsize_e        cmd_size_i,
   input  logic [31:0]   cmd_wdata_i,

   output logic          rsp_valid_o,
   output logic [31:0]   rsp_data_o
);

   // AHB bus.
   logic [AW-1:0] s_haddr;
   htrans_e       s_htrans;
   hsize_e        s_hsize;
   logic          s_hwrite;
   logic          s_hsel;
   logic [31:0]   s_hwdata;
   logic [31:0]   s_hrdata;

   // read tag for the unpacker.
   logic          rd_phase;
   hsize_e        rd_size;
   logic [1:0]    rd_lane;

   ahb_cmd_master #(
      .MEM_SIZE (MEM_SIZE)
   ) u_master (
      .s_clk_i     (s_clk_i),
      .s_resetn_i  (s_resetn_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_write_i (cmd_write_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_size_i  (cmd_size_i),
      .cmd_wdata_i (cmd_wdata_i),
      .s_haddr_o   (s_haddr),
      .s_htrans_o  (s_htrans),
      .s_hsize_o   (s_hsize),
      .s_hwrite_o  (s_hwrite),
      .s_hsel_o    (s_hsel),
      .s_hwdata_o  (s_hwdata),
      .rd_phase_o  (rd_phase),
      .rd_size_o   (rd_size),
      .rd_lane_o   (rd_lane)
   );

   ahb_ram #(
      .MEM_SIZE (MEM_SIZE)
   ) u_ram (
      .s_clk_i    (s_clk_i),
      .s_resetn_i (s_resetn_i),
      .s_haddr_i  (s_haddr),
      .s_hwdata_i (s_hwdata),
      .s_hsize_i  (s_hsize),
      .s_htrans_i (s_htrans),
      .s_hwrite_i (s_hwrite),
      .s_hsel_i   (s_hsel),
      .s_hrdata_o (s_hrdata)
   );

   ahb_rsp_unpack u_unpack (
      .s_clk_i     (s_clk_i),
      .s_resetn_i  (s_resetn_i),
      .s_hrdata_i  (s_hrdata),
      .rd_phase_i  (rd_phase),
      .rd_size_i   (rd_size),
      .rd_lane_i   (rd_lane),
      .rsp_valid_o (rsp_valid_o),
      .rsp_data_o  (rsp_data_o)
   );

endmodule : ahb_ram_sys

`default_nettype wire

//--- dv/ahb_ram_sys_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus phase checks bound to the command master.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ahb_ram_sys_checker
   import ahb_pkg::*;
(
   input  logic    s_clk_i,
   input  logic    s_resetn_i,
   input  logic    cmd_valid_i,
   input  htrans_e s_htrans_i,
   input  logic    s_hsel_i,
   input  logic    s_hwrite_i,
   input  logic    rd_phase_i
);

   logic s_rd_addr_phase;

   assign s_rd_addr_phase = s_hsel_i && (s_htrans_i == HTRANS_NONSEQ) && !s_hwrite_i;

   // a strobe turns into NONSEQ one cycle later, nothing else does.
   assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
      cmd_valid_i |=> s_htrans_i == HTRANS_NONSEQ)
      else $error("htrans is not NONSEQ one cycle after a command strobe");

   assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
      !cmd_valid_i |=> s_htrans_i == HTRANS_IDLE)
      else $error("htrans is not IDLE one cycle after a cycle with no strobe");

   // read tag follows the read address phase.
   assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
      s_rd_addr_phase |=> rd_phase_i)
      else $error("rd_phase missing after a read address phase");

   assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
      !s_rd_addr_phase |=> !rd_phase_i)
      else $error("rd_phase high without a read address phase");

   assert property (@(posedge s_clk_i)
      !s_resetn_i |=> (s_htrans_i == HTRANS_IDLE) && !s_hsel_i)
      else $error("bus not idle while reset is asserted");

endmodule : ahb_ram_sys_checker

bind ahb_cmd_master ahb_ram_sys_checker u_checker (
   .s_clk_i     (s_clk_i),
   .s_resetn_i  (s_resetn_i),
   .cmd_valid_i (cmd_valid_i),
   .s_htrans_i  (s_htrans_o),
   .s_hsel_i    (s_hsel_o),
   .s_hwrite_i  (s_hwrite_o),
   .rd_phase_i  (rd_phase_o)
);

`default_nettype wire

//--- dv/ahb_ram_sys_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AHB3-Lite RAM subsystem.
// LFSR driven commands checked against a byte-array model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ahb_ram_sys_tb
   import ahb_pkg::*;
();

   localparam int MEM_SIZE   = 4096;
   localparam int AW         = $clog2(MEM_SIZE);
   localparam int CLK_PERIOD = 40;
   localparam int N_WORD     = 32;
   localparam int N_LOOP     = 16;
   localparam int N_MIX      = 400;
   // commands issued by all tests together.
   localparam int N_CMDS     = 3 + 2*N_WORD + 15*N_LOOP + N_MIX;
   // reset, idle gaps and drain time.
   localparam int MARGIN     = 400;

   logic          s_clk = 1'b0;
   logic          s_resetn;
   logic          cmd_valid;
   logic          cmd_write;
   logic [AW-1:0] cmd_addr;
   hsize_e        cmd_size;
   logic [31:0]   cmd_wdata;
   logic          rsp_valid;
   logic [31:0]   rsp_data;

   logic [31:0]   lfsr = 32'h2f10;
   logic [7:0]    model_mem [MEM_SIZE] = '{default: 8'h00};
   logic [AW-1:0] word_addr [N_WORD];
   logic [31:0]   exp_q [$];
   int            due_q [$];
   int            cycle = 0;

   ahb_ram_sys #(
      .MEM_SIZE (MEM_SIZE)
   ) u_ahb_ram_sys (
      .s_clk_i     (s_clk),
      .s_resetn_i  (s_resetn),
      .cmd_valid_i (cmd_valid),
      .cmd_write_i (cmd_write),
      .cmd_addr_i  (cmd_addr),
      .cmd_size_i  (cmd_size),
      .cmd_wdata_i (cmd_wdata),
      .rsp_valid_o (rsp_valid),
      .rsp_data_o  (rsp_data)
   );

   always #(CLK_PERIOD/2) s_clk = ~s_clk;

   // Fibonacci LFSR, taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one LFSR step per bit taken.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic int size_bytes(input hsize_e sz);
      case (sz)
         HSIZE_BYTE: return 1;
         HSIZE_HALF: return 2;
         default:    return 4;
      endcase
   endfunction

   function automatic hsize_e pick_size();
      logic [31:0] r;
      r = take_bits(2);
      case (r[1:0])
         2'd0:    return HSIZE_BYTE;
         2'd1:    return HSIZE_HALF;
         default: return HSIZE_WORD;
      endcase
   endfunction

   // random address of nbits bits, aligned to the size.
   function automatic logic [AW-1:0] pick_addr(input hsize_e sz, input int nbits);
      logic [31:0] r;
      r = take_bits(nbits);
      return r[AW-1:0] & ~AW'(size_bytes(sz) - 1);
   endfunction

   // addressed bytes of the model, right-aligned and zero-extended.
   function automatic logic [31:0] model_read(input logic [AW-1:0] a, input hsize_e sz);
      logic [31:0] v;
      v = '0;
      for (int i = size_bytes(sz) - 1; i >= 0; i--) begin
         v = {v[23:0], model_mem[a + AW'(i)]};
      end
      return v;
   endfunction

   // write data sits on the lanes picked by the low address bits.
   function automatic void model_write(input logic [AW-1:0] a, input hsize_e sz,
                                       input logic [31:0] d);
      logic [31:0] v;
      v = d >> (8 * int'(a[1:0]));
      for (int i = 0; i < size_bytes(sz); i++) begin
         model_mem[a + AW'(i)] = v[7:0];
         v = v >> 8;
      end
   endfunction

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at time %0t", $time);
   endtask

   // one command for one cycle, the model follows in command order.
   task automatic send_cmd(input logic wr, input logic [AW-1:0] a, input hsize_e sz);
      logic [31:0] d;
      d = take_bits(32);
      @(posedge s_clk);
      cmd_valid <= 1'b1;
      cmd_write <= wr;
      cmd_addr  <= a;
      cmd_size  <= sz;
      cmd_wdata <= d;
      if (wr) begin
         model_write(a, sz, d);
      end else begin
         exp_q.push_back(model_read(a, sz));
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge s_clk);
         cmd_valid <= 1'b0;
      end
   endtask

   // a read strobe seen at the DUT input is due three edges later.
   always @(posedge s_clk) begin
      if (s_resetn) begin
         if (rsp_valid) begin
            assert (due_q.size() != 0 && exp_q.size() != 0) else begin
               $display("response at time %0t with no read pending", $time);
               abort_run();
            end
            assert (due_q[0] == cycle) else begin
               $display("response at time %0t is not three cycles after its read", $time);
               abort_run();
            end
            assert (rsp_data == exp_q[0]) else begin
               $display("[FAIL] time %0t rsp_data_o got 0x%08h expected 0x%08h",
                        $time, rsp_data, exp_q[0]);
               abort_run();
            end
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
         end else begin
            assert (due_q.size() == 0 || due_q[0] > cycle) else begin
               $display("read response missing at time %0t", $time);
               abort_run();
            end
         end
         if (cmd_valid && !cmd_write) begin
            due_q.push_back(cycle + 3);
         end
      end
      cycle++;
   end

   initial begin
      #((N_CMDS + MARGIN) * CLK_PERIOD);
      $display("watchdog expired at time %0t, the run hung", $time);
      abort_run();
   end

   initial begin
      logic [AW-1:0] a;
      logic [AW-1:0] base;
      hsize_e        sz;
      logic [31:0]   r;
      s_resetn  <= 1'b0;
      cmd_valid <= 1'b0;
      cmd_write <= 1'b0;
      cmd_addr  <= '0;
      cmd_size  <= HSIZE_WORD;
      cmd_wdata <= '0;
      repeat (5) @(posedge s_clk);
      s_resetn <= 1'b1;

      // quiet bus, then reads of memory never written.
      idle(8);
      send_cmd(1'b0, AW'(256), HSIZE_WORD);
      send_cmd(1'b0, AW'(7), HSIZE_BYTE);
      send_cmd(1'b0, AW'(34), HSIZE_HALF);
      idle(6);

      for (int i = 0; i < N_WORD; i++) begin
         word_addr[i] = pick_addr(HSIZE_WORD, AW);
         send_cmd(1'b1, word_addr[i], HSIZE_WORD);
      end
      for (int i = 0; i < N_WORD; i++) begin
         send_cmd(1'b0, word_addr[i], HSIZE_WORD);
      end
      idle(6);

      // byte and halfword merges, read back from the array.
      for (int i = 0; i < N_LOOP; i++) begin
         a = pick_addr(HSIZE_WORD, AW);
         send_cmd(1'b1, a, HSIZE_WORD);
         send_cmd(1'b1, a | pick_addr(HSIZE_BYTE, 2), HSIZE_BYTE);
         send_cmd(1'b1, a | pick_addr(HSIZE_HALF, 2), HSIZE_HALF);
         idle(2);
         send_cmd(1'b0, a, HSIZE_WORD);
      end
      idle(6);

      for (int i = 0; i < N_LOOP; i++) begin
         a = pick_addr(HSIZE_WORD, AW);
         send_cmd(1'b1, a, HSIZE_WORD);
         idle(2);
         for (int k = 0; k < 4; k++) begin
            send_cmd(1'b0, a | AW'(k), HSIZE_BYTE);
         end
         send_cmd(1'b0, a, HSIZE_HALF);
         send_cmd(1'b0, a | AW'(2), HSIZE_HALF);
      end
      idle(6);

      // reads right behind writes to the same word.
      for (int i = 0; i < N_LOOP; i++) begin
         a  = pick_addr(HSIZE_WORD, AW);
         sz = pick_size();
         send_cmd(1'b1, a | pick_addr(sz, 2), sz);
         send_cmd(1'b0, a, HSIZE_WORD);
         sz = pick_size();
         send_cmd(1'b1, a | pick_addr(sz, 2), sz);
         send_cmd(1'b0, a | pick_addr(sz, 2), sz);
      end
      idle(6);

      // small window, so words get hit again and again.
      base = pick_addr(HSIZE_WORD, AW) & ~AW'(63);
      for (int i = 0; i < N_MIX; i++) begin
         r = take_bits(3);
         if (r[2:1] == 2'd0) begin
            idle(1);
         end
         sz = pick_size();
         send_cmd(r[0], base | pick_addr(sz, 6), sz);
      end
      idle(8);

      if (exp_q.size() != 0) begin
         $display("%0d read responses never arrived", exp_q.size());
         abort_run();
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule : ahb_ram_sys_tb

`default_nettype wire

//--- verilog.f
src/ahb_pkg.sv
src/mem_pkg.sv
src/ahb_cmd_master.sv
src/ahb_ram.sv
src/ahb_rsp_unpack.sv
src/ahb_ram_sys.sv
dv/ahb_ram_sys_checker.sv
dv/ahb_ram_sys_tb.sv

//--- Makefile
# Verilator build and run for the AHB3-Lite RAM subsystem.

VERILATOR ?= verilator
TOP       ?= ahb_ram_sys_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
